//--- source/tm_pkg.sv
// Machine widths, symbol, state, head, mode and table-entry types, and the port structs
`default_nettype none

package tm_pkg;

    // ==================================================
    // Machine widths and basic types
    // ==================================================
    localparam int tape_len = 8;                   // Tape cells

    typedef logic [$clog2(tape_len)-1:0] head_t;   // Position 0 is the leftmost cell
    typedef logic                        sym_t;    // Binary alphabet
    typedef logic [1:0]                  mstate_t; // Four machine states
    typedef logic [1:0]                  bank_t;   // Table bank index
    typedef logic [tape_len-1:0]         tape_t;   // Bit 7 is the leftmost cell

    localparam bank_t custom_bank = 2'd3;          // Only writable bank

    // Head move encodings
    localparam logic move_left  = 1'b0;
    localparam logic move_right = 1'b1;

    // Table address, current state then the symbol under the head
    typedef struct packed {
        mstate_t state;
        sym_t    sym;
    } stt_addr_t;

    typedef struct packed {
        mstate_t next_state;
        sym_t    wr_sym;    // Symbol written at the head
        logic    move;      // move_left or move_right
    } stt_entry_t;

    typedef enum logic [2:0] {
        init_stt  = 3'd0,
        init_tape = 3'd1,
        init_head = 3'd2,
        run       = 3'd3,
        halt      = 3'd4,
        preset    = 3'd5
    } mode_t;

    // ==================================================
    // Port and command structs
    // ==================================================
    typedef struct packed {
        logic  custom_stt;  // Write bank 3 first, then load tape and head
        logic  manual_tape; // Load tape and head by hand
        bank_t bank;        // Table bank for non-custom boots
    } boot_t;

    typedef struct packed {
        logic wrap_en;      // Wrap at the tape ends instead of halting
        logic loop_en;      // Restart from the snapshot after a halt
    } run_cfg_t;

    typedef struct packed {
        stt_addr_t  addr;
        stt_entry_t entry;
    } stt_write_t;

    typedef struct packed {
        mode_t   mode;
        mstate_t state;
        head_t   head;
    } status_t;

    // One-cycle commands from the control FSM to the tape unit
    typedef struct packed {
        logic preset_load;
        logic tape_load;
        logic head_load;
        logic step;
        logic snap;
        logic restore;
    } tape_cmd_t;

endpackage

`default_nettype wire

//--- source/tm_preset_pkg.sv
// Preset transition tables and preset start tapes, heads and states per bank
`default_nettype none

package tm_preset_pkg;

    // ==================================================
    // Preset tables, entry is {next_state, wr_sym, move}
    // ==================================================
    localparam tm_pkg::stt_entry_t preset_table [4][8] = '{
        // Bank 0, unary incrementer
        '{4'b0001, 4'b0111, 4'b0011, 4'b0111,
          4'b0000, 4'b0000, 4'b0000, 4'b0000},
        // Bank 1, flip bits moving right
        '{4'b0011, 4'b0001, 4'b0000, 4'b0000,
          4'b0000, 4'b0000, 4'b0000, 4'b0000},
        // Bank 2, walking pattern that shuttles a 1 back and forth
        '{4'b0001, 4'b0100, 4'b0100, 4'b1011,
          4'b0011, 4'b1011, 4'b0000, 4'b0000},
        // Bank 3 is the custom bank
        '{default: 4'b0000}
    };

    // Start tapes, bit 7 is the leftmost cell
    localparam tm_pkg::tape_t preset_tape [4] = '{
        8'b1110_0000,   // Three 1s on the left
        8'b0101_1010,
        8'b1000_1011,
        8'b0000_0000
    };

    // Start head positions
    localparam tm_pkg::head_t preset_head [4] = '{3'd0, 3'd0, 3'd2, 3'd0};

    // Start states, all presets begin in state 0
    localparam tm_pkg::mstate_t preset_state [4] = '{2'd0, 2'd0, 2'd0, 2'd0};

endpackage

`default_nettype wire

//--- source/stt_bank.sv
// Four-bank transition table with fixed preset banks 0 to 2 and writable bank 3
`default_nettype none

module stt_bank (
    input  logic               clk,
    input  logic               rst_n,
    input  tm_pkg::bank_t      bank,
    input  tm_pkg::stt_addr_t  addr,
    input  logic               wr,
    input  tm_pkg::stt_write_t wr_data,
    output tm_pkg::stt_entry_t entry
);

    tm_pkg::stt_entry_t custom_q [8];   // Bank 3 register file

    // Bank 3 writes, cleared to zero on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                custom_q[i] <= '0;
            end
        end else if (wr) begin
            custom_q[wr_data.addr] <= wr_data.entry;
        end
    end

    // Combinational read, a write shows on the next lookup
    always_comb begin
        if (bank == tm_pkg::custom_bank) begin
            entry = custom_q[addr];
        end else begin
            entry = tm_preset_pkg::preset_table[bank][addr];   // Fixed presets
        end
    end

    // ==================================================
    // Checks
    // ==================================================
    a_wr_addr_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        wr |-> !$isunknown(wr_data.addr)
    );

endmodule

`default_nettype wire

//--- source/tape_unit.sv
// Tape and head registers, symbol read and write, head move with wrap or edge detect, loop snapshot
`default_nettype none

module tape_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  tm_pkg::tape_cmd_t  cmd,
    input  tm_pkg::bank_t      preset_bank,
    input  tm_pkg::tape_t      load_data,
    input  tm_pkg::stt_entry_t entry,
    input  logic               wrap_en,
    output tm_pkg::sym_t       sym,
    output logic               off_edge,
    output tm_pkg::tape_t      tape,
    output tm_pkg::head_t      head
);

    localparam tm_pkg::head_t last_pos = tm_pkg::head_t'(tm_pkg::tape_len - 1);

    tm_pkg::tape_t snap_tape;   // Start tape for loop restart
    tm_pkg::head_t snap_head;
    tm_pkg::head_t bit_idx;     // Tape bit under the head
    tm_pkg::head_t next_head;
    logic          at_edge;

    // ==================================================
    // Head mapping and move
    // ==================================================
    assign bit_idx = last_pos - head;   // Position 0 maps to bit 7
    assign sym     = tape[bit_idx];

    always_comb begin
        if (entry.move == tm_pkg::move_right) begin
            next_head = head + 1'b1;    // Rolls over to 0 at the right end
            at_edge   = (head == last_pos);
        end else begin
            next_head = head - 1'b1;    // Rolls over to 7 at the left end
            at_edge   = (head == '0);
        end
    end

    // Move would leave the tape and wrap is off
    assign off_edge = at_edge && !wrap_en;

    // ==================================================
    // Tape, head and snapshot registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tape      <= '0;
            head      <= '0;
            snap_tape <= '0;
            snap_head <= '0;
        end else begin
            if (cmd.preset_load) begin
                tape <= tm_preset_pkg::preset_tape[preset_bank];
                head <= tm_preset_pkg::preset_head[preset_bank];
            end
            if (cmd.tape_load) begin
                tape <= load_data;
            end
            if (cmd.head_load) begin
                head <= load_data[2:0];     // Head field of the load byte
            end
            if (cmd.step) begin
                tape[bit_idx] <= entry.wr_sym;
                if (!off_edge) begin
                    head <= next_head;      // Head holds on a halting step
                end
            end
            // Snapshot takes the values before the first step
            if (cmd.snap) begin
                snap_tape <= tape;
                snap_head <= head;
            end
            if (cmd.restore) begin
                tape <= snap_tape;
                head <= snap_head;
            end
        end
    end

    // Snap rides along with the first step, all other commands stand alone
    a_one_cmd : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({cmd.preset_load, cmd.tape_load, cmd.head_load, cmd.step, cmd.restore})
    );

endmodule

`default_nettype wire

//--- source/tm_control.sv
// Mode FSM, machine state register, boot latch and state snapshot for loop restart
`default_nettype none

module tm_control (
    input  logic               clk,
    input  logic               rst_n,
    input  tm_pkg::boot_t      boot,
    input  tm_pkg::run_cfg_t   run_cfg,
    input  logic               stt_wr,
    input  logic               cfg_done,
    input  logic               load,
    input  logic [7:0]         load_data,
    input  tm_pkg::stt_entry_t entry,
    input  tm_pkg::sym_t       sym,
    input  logic               off_edge,
    output tm_pkg::bank_t      bank,
    output tm_pkg::stt_addr_t  addr,
    output logic               bank_wr,
    output tm_pkg::tape_cmd_t  cmd,
    output tm_pkg::mstate_t    mstate,
    output tm_pkg::mode_t      mode
);

    tm_pkg::bank_t   bank_q;        // Bank chosen at boot
    tm_pkg::mstate_t state_snap;    // Start state for loop restart
    logic            snap_taken;    // Snapshot done for this boot

    // ==================================================
    // Boot latch
    // ==================================================
    // Custom boots always run bank 3
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank_q <= boot.custom_stt ? tm_pkg::custom_bank : boot.bank;
        end
    end

    assign bank    = bank_q;
    assign addr    = '{state: mstate, sym: sym};
    assign bank_wr = stt_wr && (mode == tm_pkg::init_stt);  // Table writes only while configuring

    // ==================================================
    // Tape commands
    // ==================================================
    always_comb begin
        cmd             = '0;
        cmd.preset_load = (mode == tm_pkg::preset);
        cmd.tape_load   = (mode == tm_pkg::init_tape) && load;
        cmd.head_load   = (mode == tm_pkg::init_head) && load;
        cmd.step        = (mode == tm_pkg::run);
        cmd.snap        = (mode == tm_pkg::run) && !snap_taken;   // First run cycle only
        cmd.restore     = (mode == tm_pkg::halt) && run_cfg.loop_en;
    end

    // ==================================================
    // Mode FSM and machine state
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstate     <= '0;
            snap_taken <= 1'b0;
            if (boot.custom_stt) begin
                mode <= tm_pkg::init_stt;
            end else if (boot.manual_tape) begin
                mode <= tm_pkg::init_tape;
            end else begin
                mode <= tm_pkg::preset;
            end
        end else begin
            case (mode)
                tm_pkg::init_stt: begin
                    if (cfg_done) begin
                        mode <= tm_pkg::init_tape;
                    end
                end
                tm_pkg::init_tape: begin
                    if (load) begin
                        mode <= tm_pkg::init_head;    // Tape written by tape_unit
                    end
                end
                tm_pkg::init_head: begin
                    if (load) begin
                        mstate <= load_data[4:3];     // State field of the load byte
                        mode   <= tm_pkg::run;
                    end
                end
                tm_pkg::preset: begin
                    mstate <= tm_preset_pkg::preset_state[bank_q];
                    mode   <= tm_pkg::run;            // Single cycle
                end
                tm_pkg::run: begin
                    if (!snap_taken) begin
                        state_snap <= mstate;
                        snap_taken <= 1'b1;
                    end
                    mstate <= entry.next_state;       // State updates even on a halting step
                    if (off_edge) begin
                        mode <= tm_pkg::halt;
                    end
                end
                tm_pkg::halt: begin
                    // Loop restart, snapshot stays valid
                    if (run_cfg.loop_en) begin
                        mstate <= state_snap;
                        mode   <= tm_pkg::run;
                    end
                end
                default: begin
                    mode <= tm_pkg::halt;
                end
            endcase
        end
    end

    a_mode_legal : assert property (
        @(posedge clk) disable iff (!rst_n)
        mode inside {tm_pkg::init_stt, tm_pkg::init_tape, tm_pkg::init_head,
                     tm_pkg::preset, tm_pkg::run, tm_pkg::halt}
    );

endmodule

`default_nettype wire

//--- source/tm_top.sv
// Top level of the Turing machine, joins control, tape and transition table
`default_nettype none

module tm_top (
    input  logic               clk,
    input  logic               rst_n,
    input  tm_pkg::boot_t      boot,
    input  tm_pkg::run_cfg_t   run_cfg,
    input  logic               stt_wr,
    input  tm_pkg::stt_write_t stt_wr_data,
    input  logic               cfg_done,
    input  logic               load,
    input  logic [7:0]         load_data,
    output tm_pkg::tape_t      tape,
    output tm_pkg::status_t    status
);

    tm_pkg::bank_t      bank;
    tm_pkg::stt_addr_t  addr;
    logic               bank_wr;
    tm_pkg::tape_cmd_t  cmd;
    tm_pkg::stt_entry_t entry;
    tm_pkg::sym_t       sym;
    logic               off_edge;
    tm_pkg::head_t      head;
    tm_pkg::mstate_t    mstate;
    tm_pkg::mode_t      mode;

    tm_control tm_control_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .boot      (boot),
        .run_cfg   (run_cfg),
        .stt_wr    (stt_wr),
        .cfg_done  (cfg_done),
        .load      (load),
        .load_data (load_data),
        .entry     (entry),
        .sym       (sym),
        .off_edge  (off_edge),
        .bank      (bank),
        .addr      (addr),
        .bank_wr   (bank_wr),
        .cmd       (cmd),
        .mstate    (mstate),
        .mode      (mode)
    );

    stt_bank stt_bank_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .bank    (bank),
        .addr    (addr),
        .wr      (bank_wr),
        .wr_data (stt_wr_data),
        .entry   (entry)
    );

    tape_unit tape_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .preset_bank (bank),
        .load_data   (load_data),
        .entry       (entry),
        .wrap_en     (run_cfg.wrap_en),
        .sym         (sym),
        .off_edge    (off_edge),
        .tape        (tape),
        .head        (head)
    );

    // All status fields come straight from registers
    assign status = '{mode: mode, state: mstate, head: head};

endmodule

`default_nettype wire

//--- include/tm_tb_ref.svh
// Testbench reference model with table lookup, single step, run to halt and Galois LFSR
`ifndef TM_TB_REF_SVH
`define TM_TB_REF_SVH

// Visible machine registers plus a halt flag
typedef struct packed {
    tm_pkg::tape_t   tape;
    tm_pkg::head_t   head;
    tm_pkg::mstate_t state;
    logic            halted;
} ref_tm_t;

tm_pkg::stt_entry_t ref_custom [8];     // Copy of what was written to bank 3

function automatic tm_pkg::stt_entry_t ref_lookup(tm_pkg::bank_t bank, tm_pkg::stt_addr_t addr);
    if (bank == tm_pkg::custom_bank) begin
        return ref_custom[addr];
    end
    return tm_preset_pkg::preset_table[bank][addr];
endfunction

// One table step, head holds and halted sets when it would leave the tape
function automatic ref_tm_t ref_step(tm_pkg::bank_t bank, logic wrap_en, ref_tm_t cur);
    tm_pkg::head_t      idx;
    tm_pkg::stt_entry_t e;
    ref_tm_t            nxt;
    logic               at_edge;
    idx           = 3'd7 - cur.head;
    e             = ref_lookup(bank, '{state: cur.state, sym: cur.tape[idx]});
    nxt           = cur;
    nxt.tape[idx] = e.wr_sym;
    nxt.state     = e.next_state;
    at_edge       = (e.move == tm_pkg::move_left) ? (cur.head == 3'd0) : (cur.head == 3'd7);
    if (at_edge && !wrap_en) begin
        nxt.halted = 1'b1;
    end else begin
        nxt.head = (e.move == tm_pkg::move_left) ? cur.head - 3'd1 : cur.head + 3'd1;
    end
    return nxt;
endfunction

// Steps with wrap off until halt or max_steps
function automatic ref_tm_t ref_run(tm_pkg::bank_t bank, ref_tm_t start, int max_steps);
    ref_tm_t cur;
    cur = start;
    for (int i = 0; i < max_steps && !cur.halted; i++) begin
        cur = ref_step(bank, 1'b0, cur);
    end
    return cur;
endfunction

// 8-bit Galois LFSR, taps 8 6 5 4
function automatic logic [7:0] lfsr_next(logic [7:0] v);
    return v[0] ? ((v >> 1) ^ 8'hB8) : (v >> 1);
endfunction

`endif

//--- test/tm_tb.sv
// Testbench top with clock, reset, stimulus tasks, compare process and test sequence
`default_nettype none

module tm_tb;

    logic               clk;
    logic               rst_n;
    tm_pkg::boot_t      boot;
    tm_pkg::run_cfg_t   run_cfg;
    logic               stt_wr;
    tm_pkg::stt_write_t stt_wr_data;
    logic               cfg_done;
    logic               load;
    logic [7:0]         load_data;
    tm_pkg::tape_t      tape;
    tm_pkg::status_t    status;

    `include "tm_tb_ref.svh"

    // One pending comparison
    typedef struct {
        string         tag;
        ref_tm_t       exp;
        tm_pkg::mode_t mode;
    } cmp_item_t;

    localparam ref_tm_t blank = '0;   // Machine right after reset

    cmp_item_t  cmp_q [$];
    event       cmp_ev;
    int         errors    = 0;
    int         checks    = 0;
    int         tests_ok  = 0;
    int         tests_bad = 0;
    logic [7:0] lfsr;

    tm_top tm_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .boot        (boot),
        .run_cfg     (run_cfg),
        .stt_wr      (stt_wr),
        .stt_wr_data (stt_wr_data),
        .cfg_done    (cfg_done),
        .load        (load),
        .load_data   (load_data),
        .tape        (tape),
        .status      (status)
    );

    always #2 clk = ~clk;   // Period 4

    // ==================================================
    // Compare process
    // ==================================================
    always @(cmp_ev) begin : compare_outputs
        cmp_item_t       it;
        tm_pkg::status_t exp_status;
        while (cmp_q.size() > 0) begin
            it         = cmp_q.pop_front();
            exp_status = '{mode: it.mode, state: it.exp.state, head: it.exp.head};
            checks++;
            assert (tape === it.exp.tape) else begin
                $display("[FAIL] t=%0t %s: tape %b, expected %b", $time, it.tag, tape, it.exp.tape);
                errors++;
            end
            assert (status === exp_status) else begin
                $display("[FAIL] t=%0t %s: status %h, expected %h",
                         $time, it.tag, status, exp_status);
                errors++;
            end
        end
    end

    // ==================================================
    // Stimulus and wait tasks
    // ==================================================
    task automatic next_cycle();
        @(posedge clk);
        #1;                 // Drive just after the edge
    endtask

    task automatic expect_out(string tag, tm_pkg::mode_t m, ref_tm_t r);
        cmp_item_t it;
        it.tag  = tag;
        it.exp  = r;
        it.mode = m;
        cmp_q.push_back(it);
        -> cmp_ev;
    endtask

    task automatic wait_mode(tm_pkg::mode_t m);
        int n;
        n = 0;
        while (status.mode !== m && n < 200) begin
            next_cycle();
            n++;
        end
        if (status.mode !== m) begin
            $display("t=%0t: timeout, mode %s not reached within 200 cycles", $time, m.name());
            errors++;
        end
    endtask

    // Fresh bits from the LFSR, one step per bit
    function automatic logic [7:0] take_bits(int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic apply_reset(tm_pkg::boot_t b);
        rst_n = 1'b0;
        boot  = b;
        repeat (4) next_cycle();    // Boot sampled on every reset edge
        rst_n = 1'b1;
        for (int i = 0; i < 8; i++) begin
            ref_custom[i] = '0;     // Bank 3 clears on reset
        end
    endtask

    task automatic write_entry(int a, tm_pkg::stt_entry_t e);
        stt_wr        = 1'b1;
        stt_wr_data   = '{addr: tm_pkg::stt_addr_t'(a), entry: e};
        ref_custom[a] = e;
        next_cycle();
        stt_wr = 1'b0;
    endtask

    task automatic pulse_load(logic [7:0] d);
        load      = 1'b1;
        load_data = d;
        next_cycle();
        load = 1'b0;
    endtask

    task automatic pulse_cfg_done();
        cfg_done = 1'b1;
        next_cycle();
        cfg_done = 1'b0;
    endtask

    task automatic boot_preset(tm_pkg::bank_t b, output ref_tm_t start);
        apply_reset('{custom_stt: 1'b0, manual_tape: 1'b0, bank: b});
        expect_out("preset cycle", tm_pkg::preset, blank);
        next_cycle();
        start = '{tape: tm_preset_pkg::preset_tape[b], head: tm_preset_pkg::preset_head[b],
                  state: tm_preset_pkg::preset_state[b], halted: 1'b0};
        expect_out("preset start", tm_pkg::run, start);
    endtask

    // Random tape, then head and state, in init_tape and init_head
    task automatic load_manual(output ref_tm_t start);
        logic [7:0] t;
        logic [7:0] hs;
        t = take_bits(8);
        pulse_load(t);
        start = '{tape: t, head: '0, state: '0, halted: 1'b0};
        expect_out("tape loaded", tm_pkg::init_head, start);
        hs = take_bits(5);
        pulse_load(hs);
        start.head  = hs[2:0];
        start.state = hs[4:3];
        expect_out("head loaded", tm_pkg::run, start);
    endtask

    // Wrap off, halt result or 100 steps compared one by one
    task automatic run_and_compare(tm_pkg::bank_t b, ref_tm_t start);
        ref_tm_t fin;
        ref_tm_t cur;
        fin = ref_run(b, start, 100);
        if (fin.halted) begin
            wait_mode(tm_pkg::halt);
            expect_out("halt result", tm_pkg::halt, fin);
        end else begin
            cur = start;
            for (int i = 0; i < 100; i++) begin
                next_cycle();
                cur = ref_step(b, 1'b0, cur);
                expect_out("endless run step", tm_pkg::run, cur);
            end
        end
    endtask

    task automatic end_test(string name, int err0);
        next_cycle();               // Let pending compares drain
        if (errors == err0) begin
            $display("Test %s: passed", name);
            tests_ok++;
        end else begin
            $display("Test %s: failed with %0d errors", name, errors - err0);
            tests_bad++;
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin : test_seq
        ref_tm_t cur;
        ref_tm_t fin;
        int      err0;
        clk         = 1'b0;
        rst_n       = 1'b0;
        boot        = '0;
        run_cfg     = '0;
        stt_wr      = 1'b0;
        stt_wr_data = '0;
        cfg_done    = 1'b0;
        load        = 1'b0;
        load_data   = '0;
        lfsr        = 8'd64;        // Seed

        for (int b = 0; b < 3; b++) begin
            err0 = errors;
            boot_preset(tm_pkg::bank_t'(b), cur);
            run_and_compare(tm_pkg::bank_t'(b), cur);
            end_test($sformatf("preset %0d to halt", b), err0);
        end

        err0    = errors;
        run_cfg = '{wrap_en: 1'b1, loop_en: 1'b0};
        boot_preset(2'd1, cur);
        for (int i = 0; i < 20; i++) begin
            next_cycle();
            cur = ref_step(2'd1, 1'b1, cur);   // One step per run cycle
            expect_out("wrap step", tm_pkg::run, cur);
        end
        end_test("preset 1 with wrap", err0);

        run_cfg = '0;
        for (int r = 0; r < 4; r++) begin
            err0 = errors;
            apply_reset('{custom_stt: 1'b1, manual_tape: 1'b0, bank: 2'd1});
            expect_out("custom boot", tm_pkg::init_stt, blank);
            for (int a = 0; a < 8; a++) begin
                write_entry(a, tm_pkg::stt_entry_t'(take_bits(4)));
            end
            pulse_cfg_done();
            load_manual(cur);
            run_and_compare(tm_pkg::custom_bank, cur);
            end_test($sformatf("custom table %0d", r), err0);
        end

        for (int b = 0; b < 3; b++) begin
            err0 = errors;
            apply_reset('{custom_stt: 1'b0, manual_tape: 1'b1, bank: tm_pkg::bank_t'(b)});
            expect_out("manual boot", tm_pkg::init_tape, blank);
            load_manual(cur);
            run_and_compare(tm_pkg::bank_t'(b), cur);
            end_test($sformatf("manual tape on bank %0d", b), err0);
        end

        // Loop mode, halt shows for one cycle then the start values return
        err0    = errors;
        run_cfg = '{wrap_en: 1'b0, loop_en: 1'b1};
        boot_preset(2'd0, cur);
        fin = ref_run(2'd0, cur, 100);
        wait_mode(tm_pkg::halt);
        expect_out("loop halt", tm_pkg::halt, fin);
        next_cycle();
        expect_out("loop restart", tm_pkg::run, cur);
        wait_mode(tm_pkg::halt);
        expect_out("second halt", tm_pkg::halt, fin);
        end_test("loop restart", err0);

        err0    = errors;
        run_cfg = '0;
        apply_reset('{custom_stt: 1'b0, manual_tape: 1'b0, bank: 2'd1});
        stt_wr      = 1'b1;         // Held through the preset cycle and first run cycle
        stt_wr_data = '{addr: '0, entry: 4'b1111};
        load        = 1'b1;
        load_data   = 8'hFF;
        cfg_done    = 1'b1;
        next_cycle();
        cur = '{tape: tm_preset_pkg::preset_tape[1], head: tm_preset_pkg::preset_head[1],
                state: tm_preset_pkg::preset_state[1], halted: 1'b0};
        expect_out("strobes in preset", tm_pkg::run, cur);
        next_cycle();
        stt_wr   = 1'b0;
        load     = 1'b0;
        cfg_done = 1'b0;
        run_and_compare(2'd1, cur);
        end_test("strobes outside their modes", err0);

        // Bank 3 runs a bit flipper, table writes in run would make it turn back
        err0 = errors;
        apply_reset('{custom_stt: 1'b1, manual_tape: 1'b0, bank: 2'd0});
        for (int a = 0; a < 8; a++) begin
            write_entry(a, tm_preset_pkg::preset_table[1][a]);
        end
        pulse_cfg_done();
        pulse_load(8'h00);
        pulse_load(8'h00);          // Head 0, state 0
        cur = '{tape: 8'h00, head: 3'd0, state: 2'd0, halted: 1'b0};
        expect_out("custom start", tm_pkg::run, cur);
        stt_wr = 1'b1;
        for (int a = 0; a < 2; a++) begin
            stt_wr_data = '{addr: tm_pkg::stt_addr_t'(a), entry: 4'b0000};  // Move left
            next_cycle();
        end
        stt_wr = 1'b0;
        run_and_compare(tm_pkg::custom_bank, cur);
        end_test("table writes during run", err0);

        $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_ok, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
source/tm_pkg.sv
source/tm_preset_pkg.sv
source/stt_bank.sv
source/tape_unit.sv
source/tm_control.sv
source/tm_top.sv
test/tm_tb.sv

//--- Bender.yml
package:
  name: turing_machine

sources:
  # Packages first, then the RTL units and the top level
  - files:
      - source/tm_pkg.sv
      - source/tm_preset_pkg.sv
      - source/stt_bank.sv
      - source/tape_unit.sv
      - source/tm_control.sv
      - source/tm_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tm_tb.sv
